// ==== color_mapper.sv ====
// colour mapper top level
// hit tests for enemies, player and lives hud feed the priority stage,
// the pixel comes out one clock after the scan position

`timescale 1ns/1ps

`include "color_mapper_cfg.svh"

`default_nettype none

module color_mapper
	import display_geom_pkg::*;
	import pixel_color_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  coord_t draw_x,
	input  coord_t draw_y,
	input  coord_t ship_x,
	input  coord_t ship_y,
	input  coord_t ship_size,
	input  coord_t laser_x [`NUM_LASERS],
	input  coord_t laser_y [`NUM_LASERS],
	input  logic   laser_en [`NUM_LASERS],
	input  coord_t enemy_x [`NUM_ENEMIES],
	input  coord_t enemy_y [`NUM_ENEMIES],
	input  logic   enemy_en [`NUM_ENEMIES],
	input  logic   enemy_explode [`NUM_ENEMIES],
	input  coord_t lives_x,
	input  coord_t lives_y,
	input  lives_t num_lives,
	input  rgb_t   bg_rgb,
	input  texel_t ship_texel,
	input  texel_t enemy_texel,
	input  texel_t explosion_texel,
	input  rgb_t   laser_rgb,
	input  logic   lose_game,
	input  logic   win_game,
	output chan_t  red,
	output chan_t  green,
	output chan_t  blue
);

	logic enemy_hit;
	logic enemy_exploding;
	logic ship_hit;
	logic laser_hit;
	logic lives_hit;
	rgb_t lives_rgb;

	// ----------------------------------------
	// object hit tests
	// ----------------------------------------
	enemy_scan u_enemy_scan (
		.draw_x          (draw_x),
		.draw_y          (draw_y),
		.enemy_x         (enemy_x),
		.enemy_y         (enemy_y),
		.enemy_en        (enemy_en),
		.enemy_explode   (enemy_explode),
		.enemy_hit       (enemy_hit),
		.enemy_exploding (enemy_exploding)
	);

	player_scan u_player_scan (
		.draw_x    (draw_x),
		.draw_y    (draw_y),
		.ship_x    (ship_x),
		.ship_y    (ship_y),
		.ship_size (ship_size),
		.laser_x   (laser_x),
		.laser_y   (laser_y),
		.laser_en  (laser_en),
		.ship_hit  (ship_hit),
		.laser_hit (laser_hit)
	);

	// hearts in the corner
	lives_hud u_lives_hud (
		.draw_x    (draw_x),
		.draw_y    (draw_y),
		.lives_x   (lives_x),
		.lives_y   (lives_y),
		.num_lives (num_lives),
		.lives_hit (lives_hit),
		.lives_rgb (lives_rgb)
	);

	// ----------------------------------------
	// final selection and output register
	// ----------------------------------------
	pixel_priority u_pixel_priority (
		.clk             (clk),
		.rst_n           (rst_n),
		.lose_game       (lose_game),
		.win_game        (win_game),
		.ship_hit        (ship_hit),
		.laser_hit       (laser_hit),
		.enemy_hit       (enemy_hit),
		.enemy_exploding (enemy_exploding),
		.lives_hit       (lives_hit),
		.lives_rgb       (lives_rgb),
		.bg_rgb          (bg_rgb),
		.laser_rgb       (laser_rgb),
		.ship_texel      (ship_texel),
		.enemy_texel     (enemy_texel),
		.explosion_texel (explosion_texel),
		.red             (red),
		.green           (green),
		.blue            (blue)
	);

endmodule

`default_nettype wire

// ==== color_mapper_asserts.sv ====
// colour mapper assertions
// output sanity, reset clearing and end screen pass-through

`timescale 1ns/1ps

`include "color_mapper_cfg.svh"

`default_nettype none

module color_mapper_asserts
	import pixel_color_pkg::*;
(
	input logic  clk,
	input logic  rst_n,
	input logic  lose_game,
	input logic  win_game,
	input rgb_t  bg_rgb,
	input chan_t red,
	input chan_t green,
	input chan_t blue
);

	int   fail_count = 0;
	rgb_t pix;

	assign pix = {red, green, blue};

	a_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(pix))
	else
	begin
		fail_count++;
		$error("output pixel is unknown after reset");
	end

	// a reset edge clears the output register
	a_reset_zero: assert property (@(posedge clk) !rst_n |=> (pix == '0))
	else
	begin
		fail_count++;
		$error("output pixel not cleared by reset");
	end

	// end screen shows last cycle's background
	a_end_screen: assert property (@(posedge clk) disable iff (!rst_n)
		(lose_game || win_game) |=> (pix == $past(bg_rgb)))
	else
	begin
		fail_count++;
		$error("end screen did not pass the background through");
	end

endmodule

bind color_mapper color_mapper_asserts u_asserts (
	.clk       (clk),
	.rst_n     (rst_n),
	.lose_game (lose_game),
	.win_game  (win_game),
	.bg_rgb    (bg_rgb),
	.red       (red),
	.green     (green),
	.blue      (blue)
);

`default_nettype wire

// ==== color_mapper_cfg.svh ====
// colour mapper configuration
// screen geometry, object counts and sizes, heart glyph and fixed colours

`ifndef COLOR_MAPPER_CFG_SVH
`define COLOR_MAPPER_CFG_SVH

// ----------------------------------------
// screen and object counts
// ----------------------------------------
`define COORD_W         10
`define NUM_ENEMIES     12
`define NUM_LASERS      4

// ----------------------------------------
// object sizes in pixels
// ----------------------------------------
`define ENEMY_SIZE      30
`define LASER_W         4
`define LASER_H         16

// heart glyph, 16 rows of 8 columns
`define LIVES_ROWS      16
`define GLYPH_W         8

// row r sits at bits r*8 upward, bit c set means column c is lit
`define HEART_GLYPH     128'h0000_0000_0000_183c_7eff_ffff_6600_0000

// ----------------------------------------
// colours
// ----------------------------------------
// sprite texel value that lets the background through
`define TRANSPARENT_KEY 24'hffc0cb

// heart foreground, pure red
`define LIFE_FG         12'hf00

`endif

// ==== display_geom_pkg.sv ====
// screen geometry types
// coordinates, enemy index and life count shared by the scanners

`default_nettype none

`include "color_mapper_cfg.svh"

package display_geom_pkg;

	// unsigned screen coordinate
	typedef logic [`COORD_W-1:0] coord_t;

	// wide enough for every enemy slot
	typedef logic [$clog2(`NUM_ENEMIES)-1:0] enemy_idx_t;

	// remaining lives, 0 to 3
	typedef logic [1:0] lives_t;

endpackage

`default_nettype wire

// ==== enemy_scan.sv ====
// enemy hit test
// finds the lowest enabled enemy whose box holds the pixel
// and reports whether that enemy is currently exploding

`timescale 1ns/1ps

`include "color_mapper_cfg.svh"

`default_nettype none

module enemy_scan
	import display_geom_pkg::*;
(
	input  coord_t draw_x,
	input  coord_t draw_y,
	input  coord_t enemy_x [`NUM_ENEMIES],
	input  coord_t enemy_y [`NUM_ENEMIES],
	input  logic   enemy_en [`NUM_ENEMIES],
	input  logic   enemy_explode [`NUM_ENEMIES],
	output logic   enemy_hit,
	output logic   enemy_exploding
);

	logic [`NUM_ENEMIES-1:0] in_box;
	enemy_idx_t              hit_idx;

	// per-enemy box test, disabled slots never hit
	for (genvar i = 0; i < `NUM_ENEMIES; i++)
	begin : g_box
		assign in_box[i] = enemy_en[i] &&
			(draw_x >= enemy_x[i]) && (draw_x < enemy_x[i] + `ENEMY_SIZE) &&
			(draw_y >= enemy_y[i]) && (draw_y < enemy_y[i] + `ENEMY_SIZE);
	end

	// walk downward so the lowest index is written last
	always_comb
	begin
		hit_idx = '0;
		for (int i = `NUM_ENEMIES - 1; i >= 0; i--)
		begin
			if (in_box[i])
				hit_idx = enemy_idx_t'(i);
		end
	end

	assign enemy_hit = |in_box;

	// hit_idx stays 0 on a miss, so the lookup is always in range
	assign enemy_exploding = enemy_hit && enemy_explode[hit_idx];

endmodule

`default_nettype wire

// ==== lives_hud.sv ====
// lives display
// one heart glyph per remaining life, read from a small glyph rom

`timescale 1ns/1ps

`include "color_mapper_cfg.svh"

`default_nettype none

module lives_hud
	import display_geom_pkg::*;
	import pixel_color_pkg::*;
(
	input  coord_t draw_x,
	input  coord_t draw_y,
	input  coord_t lives_x,
	input  coord_t lives_y,
	input  lives_t num_lives,
	output logic   lives_hit,
	output rgb_t   lives_rgb
);

	localparam logic [`LIVES_ROWS*`GLYPH_W-1:0] HEART = `HEART_GLYPH;

	coord_t                         row_off;
	logic [$clog2(`LIVES_ROWS)-1:0] glyph_row;
	logic [`GLYPH_W-1:0]            glyph_bits;
	logic                           lit;

	// half-open box, zero width when no lives are left
	assign lives_hit = (draw_x >= lives_x) && (draw_x < lives_x + num_lives * `GLYPH_W) &&
		(draw_y >= lives_y) && (draw_y < lives_y + `LIVES_ROWS);

	assign row_off   = draw_y - lives_y;
	assign glyph_row = row_off[$clog2(`LIVES_ROWS)-1:0];

	// glyph rom
	always_comb
	begin
		case (glyph_row)
			0:  glyph_bits = HEART[0*`GLYPH_W +: `GLYPH_W];
			1:  glyph_bits = HEART[1*`GLYPH_W +: `GLYPH_W];
			2:  glyph_bits = HEART[2*`GLYPH_W +: `GLYPH_W];
			3:  glyph_bits = HEART[3*`GLYPH_W +: `GLYPH_W];
			4:  glyph_bits = HEART[4*`GLYPH_W +: `GLYPH_W];
			5:  glyph_bits = HEART[5*`GLYPH_W +: `GLYPH_W];
			6:  glyph_bits = HEART[6*`GLYPH_W +: `GLYPH_W];
			7:  glyph_bits = HEART[7*`GLYPH_W +: `GLYPH_W];
			8:  glyph_bits = HEART[8*`GLYPH_W +: `GLYPH_W];
			9:  glyph_bits = HEART[9*`GLYPH_W +: `GLYPH_W];
			10: glyph_bits = HEART[10*`GLYPH_W +: `GLYPH_W];
			11: glyph_bits = HEART[11*`GLYPH_W +: `GLYPH_W];
			12: glyph_bits = HEART[12*`GLYPH_W +: `GLYPH_W];
			13: glyph_bits = HEART[13*`GLYPH_W +: `GLYPH_W];
			14: glyph_bits = HEART[14*`GLYPH_W +: `GLYPH_W];
			default: glyph_bits = HEART[15*`GLYPH_W +: `GLYPH_W];
		endcase
	end

	// hearts sit on 8-pixel columns, so the low x bits pick the column
	assign lit = glyph_bits[draw_x[2:0]];

	assign lives_rgb = lit ? rgb_t'(`LIFE_FG) : rgb_t'('0);

endmodule

`default_nettype wire

// ==== pixel_color_pkg.sv ====
// pixel colour types
// output channels, 12-bit rgb and the 24-bit sprite texel

`default_nettype none

package pixel_color_pkg;

	// one output channel of the vga dac
	typedef logic [3:0] chan_t;

	typedef struct packed {
		chan_t red;
		chan_t green;
		chan_t blue;
	} rgb_t;

	// sprite ram channels, 8 bits each
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} texel_ch_t;

	// compared whole against the key, displayed per channel
	typedef union packed {
		logic [23:0] word;
		texel_ch_t   ch;
	} texel_t;

endpackage

`default_nettype wire

// ==== pixel_priority.sv ====
// layer priority and output register
// picks the visible layer, applies the sprite transparency key
// and registers the final rgb pixel

`timescale 1ns/1ps

`include "color_mapper_cfg.svh"

`default_nettype none

module pixel_priority
	import pixel_color_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   lose_game,
	input  logic   win_game,
	input  logic   ship_hit,
	input  logic   laser_hit,
	input  logic   enemy_hit,
	input  logic   enemy_exploding,
	input  logic   lives_hit,
	input  rgb_t   lives_rgb,
	input  rgb_t   bg_rgb,
	input  rgb_t   laser_rgb,
	input  texel_t ship_texel,
	input  texel_t enemy_texel,
	input  texel_t explosion_texel,
	output chan_t  red,
	output chan_t  green,
	output chan_t  blue
);

	rgb_t pix_next;
	rgb_t pix_q;

	// background where the texel matches the key, else top nibbles
	function automatic rgb_t keyed(input texel_t t, input rgb_t bg);
		rgb_t c;
		if (t.word == `TRANSPARENT_KEY)
			c = bg;
		else
		begin
			c.red   = t.ch.red[7:4];
			c.green = t.ch.green[7:4];
			c.blue  = t.ch.blue[7:4];
		end
		return c;
	endfunction

	// ----------------------------------------
	// layer select, first match wins
	// ----------------------------------------
	always_comb
	begin
		if (lose_game || win_game)
			pix_next = bg_rgb;
		else if (ship_hit)
			pix_next = keyed(ship_texel, bg_rgb);
		else if (laser_hit)
			pix_next = laser_rgb;
		else if (enemy_hit && enemy_exploding)
			pix_next = keyed(explosion_texel, bg_rgb);
		else if (enemy_hit)
			pix_next = keyed(enemy_texel, bg_rgb);
		else if (lives_hit)
			pix_next = lives_rgb;
		else
			pix_next = bg_rgb;
	end

	// single pipeline stage
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pix_q <= '0;
		else
			pix_q <= pix_next;
	end

	assign red   = pix_q.red;
	assign green = pix_q.green;
	assign blue  = pix_q.blue;

endmodule

`default_nettype wire

// ==== player_scan.sv ====
// player hit test
// ship square and the four player laser boxes

`timescale 1ns/1ps

`include "color_mapper_cfg.svh"

`default_nettype none

module player_scan
	import display_geom_pkg::*;
(
	input  coord_t draw_x,
	input  coord_t draw_y,
	input  coord_t ship_x,
	input  coord_t ship_y,
	input  coord_t ship_size,
	input  coord_t laser_x [`NUM_LASERS],
	input  coord_t laser_y [`NUM_LASERS],
	input  logic   laser_en [`NUM_LASERS],
	output logic   ship_hit,
	output logic   laser_hit
);

	coord_t                 dist_x;
	coord_t                 dist_y;
	logic [`NUM_LASERS-1:0] laser_box;

	// ----------------------------------------
	// ship
	// ----------------------------------------
	// 10-bit differences wrap when left of or above the ship
	assign dist_x = draw_x - ship_x;
	assign dist_y = draw_y - ship_y;

	// inclusive on both ends
	assign ship_hit = (dist_x <= ship_size) && (dist_y <= ship_size);

	// ----------------------------------------
	// lasers
	// ----------------------------------------
	for (genvar i = 0; i < `NUM_LASERS; i++)
	begin : g_laser
		assign laser_box[i] = laser_en[i] &&
			(draw_x >= laser_x[i]) && (draw_x < laser_x[i] + `LASER_W) &&
			(draw_y >= laser_y[i]) && (draw_y < laser_y[i] + `LASER_H);
	end

	assign laser_hit = |laser_box;

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
display_geom_pkg.sv
pixel_color_pkg.sv
enemy_scan.sv
player_scan.sv
lives_hud.sv
pixel_priority.sv
color_mapper.sv
color_mapper_asserts.sv
tb_clock_gen.sv
tb_color_mapper.sv

// ==== tb_clock_gen.sv ====
// testbench clock and reset
// 100 ns clock, reset held low for the first three rising edges

`timescale 1ns/1ps

`default_nettype none

module tb_clock_gen
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// release a little after the third edge
	initial
	begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#10;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb_color_mapper.sv ====
// colour mapper testbench
// drives scan positions and game objects, checks each output pixel
// against a behavioural model of the layer rules

`timescale 1ns/1ps

`include "color_mapper_cfg.svh"

`default_nettype none

module tb_color_mapper
	import display_geom_pkg::*;
	import pixel_color_pkg::*;
();

	localparam logic [`LIVES_ROWS*`GLYPH_W-1:0] HEART = `HEART_GLYPH;

	logic   clk;
	logic   rst_n;
	coord_t draw_x;
	coord_t draw_y;
	coord_t ship_x;
	coord_t ship_y;
	coord_t ship_size;
	coord_t laser_x [`NUM_LASERS];
	coord_t laser_y [`NUM_LASERS];
	logic   laser_en [`NUM_LASERS];
	coord_t enemy_x [`NUM_ENEMIES];
	coord_t enemy_y [`NUM_ENEMIES];
	logic   enemy_en [`NUM_ENEMIES];
	logic   enemy_explode [`NUM_ENEMIES];
	coord_t lives_x;
	coord_t lives_y;
	lives_t num_lives;
	rgb_t   bg_rgb;
	texel_t ship_texel;
	texel_t enemy_texel;
	texel_t explosion_texel;
	rgb_t   laser_rgb;
	logic   lose_game;
	logic   win_game;
	chan_t  red;
	chan_t  green;
	chan_t  blue;
	int     seed = 98;

	tb_clock_gen u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	color_mapper uut (.*);

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic bit box_contains(int px, int py, int left, int top, int w, int h);
		return (px >= left) && (px < left + w) && (py >= top) && (py < top + h);
	endfunction

	// top nibble of each byte unless the texel is the key colour
	function automatic rgb_t sprite_color(logic [23:0] t, rgb_t bg);
		if (t == `TRANSPARENT_KEY)
			return bg;
		return {t[23:20], t[15:12], t[7:4]};
	endfunction

	function automatic rgb_t expected_pixel();
		logic [`COORD_W-1:0] dx;
		logic [`COORD_W-1:0] dy;
		bit                  ship_on;
		bit                  laser_on;
		bit                  enemy_on;
		bit                  boom;
		bit                  lives_on;
		bit                  lit;
		int                  row;
		dx = draw_x - ship_x;
		dy = draw_y - ship_y;
		ship_on = (dx <= ship_size) && (dy <= ship_size);
		laser_on = 0;
		for (int i = 0; i < `NUM_LASERS; i++)
			if (laser_en[i] && box_contains(draw_x, draw_y, laser_x[i], laser_y[i],
				`LASER_W, `LASER_H))
				laser_on = 1;
		// lowest enabled index wins
		enemy_on = 0;
		boom = 0;
		for (int i = 0; i < `NUM_ENEMIES; i++)
			if (!enemy_on && enemy_en[i] && box_contains(draw_x, draw_y, enemy_x[i],
				enemy_y[i], `ENEMY_SIZE, `ENEMY_SIZE))
			begin
				enemy_on = 1;
				boom = enemy_explode[i];
			end
		lives_on = box_contains(draw_x, draw_y, lives_x, lives_y, num_lives * `GLYPH_W,
			`LIVES_ROWS);
		lit = 0;
		if (lives_on)
		begin
			row = int'(draw_y) - int'(lives_y);
			lit = HEART[row * `GLYPH_W + int'(draw_x[2:0])];
		end
		if (lose_game || win_game)
			return bg_rgb;
		if (ship_on)
			return sprite_color(ship_texel, bg_rgb);
		if (laser_on)
			return laser_rgb;
		if (enemy_on)
			return sprite_color(boom ? explosion_texel : enemy_texel, bg_rgb);
		if (lives_on)
			return lit ? rgb_t'(`LIFE_FG) : rgb_t'(0);
		return bg_rgb;
	endfunction

	task automatic check_value(input string name, input logic [11:0] got,
		input logic [11:0] exp);
		if (got !== exp)
		begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Test failed");
			$fatal(1, "output mismatch");
		end
	endtask

	// expected value taken mid-cycle, checked just after the next edge
	initial
	begin : compare
		rgb_t exp_pix;
		forever
		begin
			@(negedge clk);
			exp_pix = (rst_n === 1'b1) ? expected_pixel() : rgb_t'(0);
			@(posedge clk);
			#1;
			check_value("red", red, exp_pix.red);
			check_value("green", green, exp_pix.green);
			check_value("blue", blue, exp_pix.blue);
		end
	end

	// a bound assertion failure stops the run at the same edge
	initial
	begin : watch_asserts
		forever
		begin
			@(posedge clk);
			#2;
			if (uut.u_asserts.fail_count != 0)
			begin
				$display("a bound assertion on the colour mapper failed");
				$display("Test failed");
				$fatal(1, "assertion failure");
			end
		end
	end

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	function automatic int pick_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic show_pixel(input int x, input int y);
		draw_x = coord_t'(x);
		draw_y = coord_t'(y);
		next_cycle();
	endtask

	task automatic clear_scene();
		draw_x = 0;
		draw_y = 0;
		ship_x = 1023;
		ship_y = 1023;
		ship_size = 0;
		for (int i = 0; i < `NUM_LASERS; i++)
		begin
			laser_x[i] = 0;
			laser_y[i] = 0;
			laser_en[i] = 0;
		end
		for (int i = 0; i < `NUM_ENEMIES; i++)
		begin
			enemy_x[i] = 0;
			enemy_y[i] = 0;
			enemy_en[i] = 0;
			enemy_explode[i] = 0;
		end
		lives_x = 0;
		lives_y = 0;
		num_lives = 0;
		bg_rgb = 12'h123;
		laser_rgb = 12'h0f0;
		ship_texel = 24'h88aacc;
		enemy_texel = 24'h40c020;
		explosion_texel = 24'hf0a010;
		lose_game = 0;
		win_game = 0;
	endtask

	// reset is sampled on the rising edge, stimulus resumes 10 ns later
	task automatic wait_for_reset();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1 && cycles < 20)
		begin
			@(posedge clk);
			cycles++;
		end
		if (rst_n !== 1'b1)
		begin
			$display("reset was not released within 20 cycles");
			$display("Test failed");
			$fatal(1, "reset timeout");
		end
		#10;
	endtask

	task automatic randomize_scene();
		ship_x = coord_t'(pick_below(128));
		ship_y = coord_t'(pick_below(128));
		ship_size = coord_t'(pick_below(16));
		for (int i = 0; i < `NUM_LASERS; i++)
		begin
			laser_x[i] = coord_t'(pick_below(128));
			laser_y[i] = coord_t'(pick_below(128));
			laser_en[i] = pick_below(2) == 1;
		end
		for (int i = 0; i < `NUM_ENEMIES; i++)
		begin
			enemy_x[i] = coord_t'(pick_below(128));
			enemy_y[i] = coord_t'(pick_below(128));
			enemy_en[i] = pick_below(2) == 1;
			enemy_explode[i] = pick_below(2) == 1;
		end
		lives_x = coord_t'(pick_below(128));
		lives_y = coord_t'(pick_below(128));
		num_lives = lives_t'(pick_below(4));
		bg_rgb = rgb_t'(pick_below(4096));
		laser_rgb = rgb_t'(pick_below(4096));
		ship_texel = (pick_below(4) == 0) ? `TRANSPARENT_KEY : texel_t'(pick_below(1 << 24));
		enemy_texel = (pick_below(4) == 0) ? `TRANSPARENT_KEY : texel_t'(pick_below(1 << 24));
		explosion_texel = (pick_below(4) == 0) ? `TRANSPARENT_KEY :
			texel_t'(pick_below(1 << 24));
		lose_game = pick_below(16) == 0;
		win_game = pick_below(16) == 0;
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial
	begin
		clear_scene();
		wait_for_reset();

		// end screen over a ship pixel
		ship_x = 50;
		ship_y = 50;
		ship_size = 10;
		for (int i = 0; i < 8; i++)
		begin
			lose_game = i < 4;
			win_game = i >= 3;
			bg_rgb = rgb_t'(pick_below(4096));
			show_pixel(52 + i, 55);
		end

		// ship above laser and enemy, keyed and opaque texel
		clear_scene();
		ship_x = 100;
		ship_y = 100;
		ship_size = 20;
		enemy_x[0] = 95;
		enemy_y[0] = 95;
		enemy_en[0] = 1;
		laser_x[0] = 104;
		laser_y[0] = 100;
		laser_en[0] = 1;
		ship_texel = `TRANSPARENT_KEY;
		show_pixel(105, 105);
		ship_texel = 24'h3a7fe1;
		show_pixel(105, 105);
		show_pixel(120, 120);
		show_pixel(121, 105);
		show_pixel(99, 105);

		// overlapping enemies, lowest enabled index decides
		clear_scene();
		enemy_x[1] = 205;
		enemy_y[1] = 205;
		enemy_explode[1] = 1;
		enemy_x[3] = 200;
		enemy_y[3] = 200;
		enemy_en[3] = 1;
		enemy_explode[3] = 1;
		enemy_x[5] = 210;
		enemy_y[5] = 210;
		enemy_en[5] = 1;
		for (int pass = 0; pass < 4; pass++)
		begin
			enemy_en[3] = pass < 2;
			explosion_texel = pass[0] ? `TRANSPARENT_KEY : 24'hf0a010;
			enemy_texel = pass[0] ? 24'h40c020 : `TRANSPARENT_KEY;
			for (int y = 195; y < 250; y += 6)
				for (int x = 195; x < 250; x += 6)
					show_pixel(x, y);
		end

		// laser over enemy and lives, on and off
		// the enemy ends above the last hud rows
		clear_scene();
		lives_x = 300;
		lives_y = 300;
		num_lives = 3;
		enemy_x[2] = 290;
		enemy_y[2] = 280;
		enemy_en[2] = 1;
		laser_x[1] = 302;
		laser_y[1] = 296;
		for (int pass = 0; pass < 2; pass++)
		begin
			laser_en[1] = pass == 0;
			for (int y = 294; y < 318; y++)
				for (int x = 298; x < 309; x++)
					show_pixel(x, y);
		end

		// lives box for each life count
		clear_scene();
		lives_x = 400;
		lives_y = 40;
		for (int n = 0; n < 4; n++)
		begin
			num_lives = lives_t'(n);
			for (int y = 38; y < 58; y++)
				for (int x = 398; x < 402 + 8 * n; x++)
					show_pixel(x, y);
		end

		// random scenes in a small window so objects collide often
		for (int i = 0; i < 3000; i++)
		begin
			randomize_scene();
			show_pixel(pick_below(128), pick_below(128));
		end

		next_cycle();
		next_cycle();
		if (uut.u_asserts.fail_count == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("assertion failures: %0d", uut.u_asserts.fail_count);
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
